// ==== Bender.yml ====
package:
  name: ctr_stream

sources:
  - rtl/ctr_pkg.sv
  - rtl/ctr_blk_if.sv
  - rtl/stream_fifo.sv
  - rtl/keystream_pipe.sv
  - rtl/ctr_xor_engine.sv
  - rtl/eof_tracker.sv
  - rtl/ctr_stream_top.sv
  - target: simulation
    files:
      - sim/ctr_stream_tb.sv

// ==== all.f ====
rtl/ctr_pkg.sv
rtl/ctr_blk_if.sv
rtl/stream_fifo.sv
rtl/keystream_pipe.sv
rtl/ctr_xor_engine.sv
rtl/eof_tracker.sv
rtl/ctr_stream_top.sv
sim/ctr_stream_tb.sv

// ==== rtl/ctr_blk_if.sv ====
// Keystream request and response link
`timescale 1ns/100ps
interface ctr_blk_if (
   input logic m_axi_mm2s_aclk
);

   // Request side
   logic              req_valid;
   ctr_pkg::blk_ctr_t req_ctr;
   ctr_pkg::key_t     req_key;

   // Keystream side, one block per request in order
   logic              ks_valid;
   ctr_pkg::data_t    ks_data;

   modport engine (
      input  m_axi_mm2s_aclk,
      output req_valid,
      output req_ctr,
      output req_key,
      input  ks_valid,
      input  ks_data
   );

   modport pipe (
      input  m_axi_mm2s_aclk,
      input  req_valid,
      input  req_ctr,
      input  req_key,
      output ks_valid,
      output ks_data
   );

endinterface

// ==== rtl/ctr_pkg.sv ====
// Counter-mode stream cipher types
package ctr_pkg;

   // One stream beat, also one keystream block
   typedef logic [127:0] data_t;

   // Cipher key
   typedef logic [255:0] key_t;

   // Block index inside a frame, restarts after every last beat
   typedef logic [15:0] blk_ctr_t;

   // Reserved output FIFO slots
   typedef logic [7:0] credit_t;

   // Defaults handed down from the top level
   localparam int DEF_ROUNDS    = 4;
   localparam int DEF_OUT_DEPTH = 16;
   localparam int DEF_EOF_DEPTH = 8;

endpackage

// ==== rtl/ctr_stream_top.sv ====
// Counter-mode stream cipher top level
`timescale 1ns/100ps
module ctr_stream_top #(
   parameter int ROUNDS    = ctr_pkg::DEF_ROUNDS,
   parameter int OUT_DEPTH = ctr_pkg::DEF_OUT_DEPTH,
   parameter int EOF_DEPTH = ctr_pkg::DEF_EOF_DEPTH
) (
   input  logic           m_axi_mm2s_aclk,
   input  logic           rst_n_i,
   input  ctr_pkg::key_t  key_i,
   input  ctr_pkg::data_t s_tdata_i,
   input  logic           s_tlast_i,
   input  logic           s_tvalid_i,
   output logic           s_tready_o,
   output ctr_pkg::data_t m_tdata_o,
   output logic           m_tlast_o,
   output logic           m_tvalid_o,
   input  logic           m_tready_i,
   output logic           eof_empty_o,
   output logic           eof_full_o,
   input  logic           eof_rd_i
);

   logic frame_done;

   ctr_blk_if blk_if (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk)
   );

   ctr_xor_engine #(
      .ROUNDS    (ROUNDS),
      .OUT_DEPTH (OUT_DEPTH)
   ) engine_i (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .key_i           (key_i),
      .s_tdata_i       (s_tdata_i),
      .s_tlast_i       (s_tlast_i),
      .s_tvalid_i      (s_tvalid_i),
      .s_tready_o      (s_tready_o),
      .m_tdata_o       (m_tdata_o),
      .m_tlast_o       (m_tlast_o),
      .m_tvalid_o      (m_tvalid_o),
      .m_tready_i      (m_tready_i),
      .eof_full_i      (eof_full_o),
      .m_frame_done_o  (frame_done),
      .blk             (blk_if.engine)
   );

   keystream_pipe #(
      .ROUNDS (ROUNDS)
   ) pipe_i (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .blk             (blk_if.pipe)
   );

   // Frames handed to the descriptor side
   eof_tracker #(
      .DEPTH (EOF_DEPTH)
   ) eof_i (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .frame_done_i    (frame_done),
      .eof_rd_i        (eof_rd_i),
      .eof_empty_o     (eof_empty_o),
      .eof_full_o      (eof_full_o)
   );

endmodule

// ==== rtl/ctr_xor_engine.sv ====
// Counter-mode XOR engine
`timescale 1ns/100ps
module ctr_xor_engine #(
   parameter int ROUNDS    = 4,
   parameter int OUT_DEPTH = 16
) (
   input  logic           m_axi_mm2s_aclk,
   input  logic           rst_n_i,
   input  ctr_pkg::key_t  key_i,
   input  ctr_pkg::data_t s_tdata_i,
   input  logic           s_tlast_i,
   input  logic           s_tvalid_i,
   output logic           s_tready_o,
   output ctr_pkg::data_t m_tdata_o,
   output logic           m_tlast_o,
   output logic           m_tvalid_o,
   input  logic           m_tready_i,
   input  logic           eof_full_i,
   output logic           m_frame_done_o,
   ctr_blk_if.engine      blk
);

   localparam int BW = $bits(ctr_pkg::data_t) + 1;

   logic              s_hs;
   logic              m_hs;
   ctr_pkg::blk_ctr_t blk_ctr_q;
   ctr_pkg::credit_t  credit_q;

   logic              align_last;
   ctr_pkg::data_t    align_data;
   logic              align_empty;

   logic              xor_valid_q;
   logic              xor_last_q;
   ctr_pkg::data_t    xor_data_q;
   logic              out_empty;

   assign s_hs = s_tvalid_i & s_tready_o;
   assign m_hs = m_tvalid_o & m_tready_i;

   // Accept only with a reserved output slot and room for the frame
   assign s_tready_o = (credit_q != '0) && !eof_full_i;

   always_ff @(posedge m_axi_mm2s_aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         blk_ctr_q     <= '0;
         credit_q      <= ctr_pkg::credit_t'(OUT_DEPTH);
         blk.req_valid <= 1'b0;
         xor_valid_q   <= 1'b0;
      end
      else
      begin
         if (s_hs)
         begin
            blk_ctr_q <= s_tlast_i ? '0 : blk_ctr_q + 1'b1;
         end
         case ({s_hs, m_hs})
            2'b10:   credit_q <= credit_q - 1'b1;
            2'b01:   credit_q <= credit_q + 1'b1;
            default: credit_q <= credit_q;
         endcase
         blk.req_valid <= s_hs;
         xor_valid_q   <= blk.ks_valid;
      end
   end

   // Counter for the pipe and the combined beat
   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (s_hs)
      begin
         blk.req_ctr <= blk_ctr_q;
      end
      xor_data_q <= blk.ks_data ^ align_data;
      xor_last_q <= align_last;
   end

   assign blk.req_key = key_i;

   // Beats wait here until their keystream block comes back
   stream_fifo #(
      .DEPTH (ROUNDS + 2),
      .WIDTH (BW)
   ) align_fifo_i (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .wr_en_i         (s_hs),
      .wr_data_i       ({s_tlast_i, s_tdata_i}),
      .rd_en_i         (blk.ks_valid & ~align_empty),
      .rd_data_o       ({align_last, align_data}),
      .empty_o         (align_empty),
      .count_o         ()
   );

   stream_fifo #(
      .DEPTH (OUT_DEPTH),
      .WIDTH (BW)
   ) out_fifo_i (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .wr_en_i         (xor_valid_q),
      .wr_data_i       ({xor_last_q, xor_data_q}),
      .rd_en_i         (m_hs),
      .rd_data_o       ({m_tlast_o, m_tdata_o}),
      .empty_o         (out_empty),
      .count_o         ()
   );

   assign m_tvalid_o     = ~out_empty;
   assign m_frame_done_o = m_hs & m_tlast_o;

endmodule

// ==== rtl/eof_tracker.sv ====
// Finished frame counter
`timescale 1ns/100ps
module eof_tracker #(
   parameter int DEPTH = 8
) (
   input  logic m_axi_mm2s_aclk,
   input  logic rst_n_i,
   input  logic frame_done_i,
   input  logic eof_rd_i,
   output logic eof_empty_o,
   output logic eof_full_o
);

   // Headroom for frames still in flight when full rises
   localparam int CW = $clog2(DEPTH + 1) + 1;

   logic [CW-1:0] cnt_q;
   logic          rd_ok;
   logic          empty_q;

   // Reads on an empty count are dropped
   assign rd_ok = eof_rd_i && (cnt_q != '0);

   always_ff @(posedge m_axi_mm2s_aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cnt_q   <= '0;
         empty_q <= 1'b1;
      end
      else
      begin
         case ({frame_done_i, rd_ok})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;
         endcase
         empty_q <= (cnt_q == '0);
      end
   end

   assign eof_empty_o = empty_q;
   assign eof_full_o  = (cnt_q >= CW'(DEPTH));

endmodule

// ==== rtl/keystream_pipe.sv ====
// Pipelined keystream generator
`timescale 1ns/100ps
module keystream_pipe #(
   parameter int ROUNDS = 4
) (
   input  logic   m_axi_mm2s_aclk,
   input  logic   rst_n_i,
   ctr_blk_if.pipe blk
);

   ctr_pkg::data_t init_state;
   ctr_pkg::data_t st_q  [ROUNDS];
   logic           vld_q [ROUNDS];

   // One add-rotate-xor round over four 32-bit lanes
   function automatic ctr_pkg::data_t round_f(
      input ctr_pkg::data_t s,
      input ctr_pkg::key_t  k,
      input int unsigned    r
   );
      logic [31:0]    lane [4];
      logic [31:0]    t;
      int unsigned    rot;
      ctr_pkg::data_t res;
      for (int j = 0; j < 4; j++)
      begin
         lane[j] = s[32*j +: 32];
      end
      for (int j = 0; j < 4; j++)
      begin
         rot = 5 + 4 * j;
         t   = lane[j] + k[32*((r + j) % 8) +: 32];
         t   = (t << rot) | (t >> (32 - rot));
         res[32*j +: 32] = t ^ lane[(j + 1) % 4];
      end
      return res;
   endfunction

   // Counter spread over every lane, then mixed with the low key half
   assign init_state = blk.req_key[127:0] ^ {4{16'h0000, blk.req_ctr}};

   for (genvar g = 0; g < ROUNDS; g++)
   begin : g_stage
      ctr_pkg::data_t stage_in;
      logic           stage_vld;

      if (g == 0)
      begin : g_first
         assign stage_in  = init_state;
         assign stage_vld = blk.req_valid;
      end
      else
      begin : g_next
         assign stage_in  = st_q[g-1];
         assign stage_vld = vld_q[g-1];
      end

      // Key is held steady while a stream runs, so it is read directly
      always_ff @(posedge m_axi_mm2s_aclk)
      begin
         st_q[g] <= round_f(stage_in, blk.req_key, g);
      end

      always_ff @(posedge m_axi_mm2s_aclk or negedge rst_n_i)
      begin
         if (!rst_n_i)
         begin
            vld_q[g] <= 1'b0;
         end
         else
         begin
            vld_q[g] <= stage_vld;
         end
      end
   end

   // Byte swap of the final block
   always_comb
   begin
      for (int b = 0; b < 16; b++)
      begin
         blk.ks_data[8*b +: 8] = st_q[ROUNDS-1][127-8*b -: 8];
      end
   end

   assign blk.ks_valid = vld_q[ROUNDS-1];

endmodule

// ==== rtl/stream_fifo.sv ====
// Synchronous first-word-fall-through FIFO
`timescale 1ns/100ps
module stream_fifo #(
   parameter int DEPTH = 4,
   parameter int WIDTH = 8
) (
   input  logic                       m_axi_mm2s_aclk,
   input  logic                       rst_n_i,
   input  logic                       wr_en_i,
   input  logic [WIDTH-1:0]           wr_data_i,
   input  logic                       rd_en_i,
   output logic [WIDTH-1:0]           rd_data_o,
   output logic                       empty_o,
   output logic [$clog2(DEPTH+1)-1:0] count_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem_q [DEPTH];
   logic [AW-1:0]    wr_ptr_q;
   logic [AW-1:0]    rd_ptr_q;
   logic [CW-1:0]    count_q;

   // Pointer advance with wrap for any depth
   function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
      if (ptr == AW'(DEPTH - 1))
      begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   always_ff @(posedge m_axi_mm2s_aclk)
   begin
      if (wr_en_i)
      begin
         mem_q[wr_ptr_q] <= wr_data_i;
      end
   end

   always_ff @(posedge m_axi_mm2s_aclk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (wr_en_i)
         begin
            wr_ptr_q <= ptr_next(wr_ptr_q);
         end
         if (rd_en_i)
         begin
            rd_ptr_q <= ptr_next(rd_ptr_q);
         end
         // Occupancy holds when both sides move together
         case ({wr_en_i, rd_en_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Head entry is always presented
   assign rd_data_o = mem_q[rd_ptr_q];
   assign empty_o   = (count_q == '0);
   assign count_o   = count_q;

endmodule

// ==== sim/ctr_stream_tb.sv ====
// Stream cipher testbench
`timescale 1ns/100ps
module ctr_stream_tb;

   localparam int NBEATS    = 22;
   localparam int PASSES    = 3;
   localparam int OUT_DEPTH = ctr_pkg::DEF_OUT_DEPTH;
   localparam int EOF_DEPTH = ctr_pkg::DEF_EOF_DEPTH;
   localparam int HOLD_CYC  = 40;
   localparam int LIMIT     = 20 * NBEATS * PASSES + 200;

   logic           m_axi_mm2s_aclk;
   logic           rst_n_i;
   ctr_pkg::key_t  key_i;
   ctr_pkg::data_t s_tdata_i;
   logic           s_tlast_i;
   logic           s_tvalid_i;
   logic           s_tready_o;
   ctr_pkg::data_t m_tdata_o;
   logic           m_tlast_o;
   logic           m_tvalid_o;
   logic           m_tready_i;
   logic           eof_empty_o;
   logic           eof_full_o;
   logic           eof_rd_i;

   // Key in words 0 and 1 followed by last flag, input and expected for each beat
   ctr_pkg::data_t vec_mem [2 + 3 * NBEATS];
   int             out_cnt;
   int             cyc_cnt;
   logic [31:0]    lfsr_q;

   ctr_stream_top dut_i (
      .m_axi_mm2s_aclk (m_axi_mm2s_aclk),
      .rst_n_i         (rst_n_i),
      .key_i           (key_i),
      .s_tdata_i       (s_tdata_i),
      .s_tlast_i       (s_tlast_i),
      .s_tvalid_i      (s_tvalid_i),
      .s_tready_o      (s_tready_o),
      .m_tdata_o       (m_tdata_o),
      .m_tlast_o       (m_tlast_o),
      .m_tvalid_o      (m_tvalid_o),
      .m_tready_i      (m_tready_i),
      .eof_empty_o     (eof_empty_o),
      .eof_full_o      (eof_full_o),
      .eof_rd_i        (eof_rd_i)
   );

   initial
   begin
      m_axi_mm2s_aclk = 1'b0;
      forever
      begin
         #10 m_axi_mm2s_aclk = ~m_axi_mm2s_aclk;
      end
   end

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      if (got !== exp)
      begin
         $display("Fail %s got %h expected %h", name, got, exp);
         $display("Test failures found");
         $fatal(1);
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Mode 0 runs free, mode 1 holds the output low at first, mode 2 stalls at random
   task automatic drive_pass(input int mode);
      int   n;
      int   cyc;
      logic go;
      n   = 0;
      cyc = 0;
      while (n < NBEATS)
      begin
         @(posedge m_axi_mm2s_aclk);
         cyc++;
         if (s_tvalid_i && s_tready_o)
         begin
            n++;
         end
         if (mode == 1 && cyc == HOLD_CYC)
         begin
            check_value("accepted_beats", n, OUT_DEPTH);
            check_value("s_tready_o", s_tready_o, 1'b0);
         end
         // An offered beat stays until it is taken
         if (!s_tvalid_i || s_tready_o)
         begin
            go = 1'b1;
            if (mode == 2)
            begin
               lfsr_q = lfsr_next(lfsr_q);
               go     = lfsr_q[0];
            end
            s_tvalid_i <= (n < NBEATS) && go;
            s_tdata_i  <= vec_mem[3 + 3 * (n % NBEATS)];
            s_tlast_i  <= vec_mem[2 + 3 * (n % NBEATS)][0];
         end
         if (mode == 2)
         begin
            lfsr_q     = lfsr_next(lfsr_q);
            m_tready_i <= lfsr_q[0];
         end
         else
         begin
            m_tready_i <= !(mode == 1 && cyc < HOLD_CYC);
         end
      end
   endtask

   task automatic drain(input int total);
      @(posedge m_axi_mm2s_aclk);
      m_tready_i <= 1'b1;
      while (out_cnt < total)
      begin
         @(posedge m_axi_mm2s_aclk);
      end
   endtask

   // Output beats compared in order across all passes
   // Frames 4 and 5 share input data, so a missed counter restart shows up here
   always @(posedge m_axi_mm2s_aclk)
   begin
      if (rst_n_i && m_tvalid_o && m_tready_i)
      begin
         check_value("m_tdata_o", m_tdata_o, vec_mem[4 + 3 * (out_cnt % NBEATS)]);
         check_value("m_tlast_o", m_tlast_o, vec_mem[2 + 3 * (out_cnt % NBEATS)][0]);
         out_cnt <= out_cnt + 1;
      end
   end

   always @(posedge m_axi_mm2s_aclk)
   begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt >= LIMIT)
      begin
         $display("Run timed out after %0d cycles", cyc_cnt);
         $display("Test failures found");
         $fatal(1);
      end
   end

   initial
   begin
      rst_n_i    = 1'b0;
      s_tdata_i  = '0;
      s_tlast_i  = 1'b0;
      s_tvalid_i = 1'b0;
      m_tready_i = 1'b1;
      eof_rd_i   = 1'b0;
      out_cnt    = 0;
      cyc_cnt    = 0;
      lfsr_q     = 32'haa61c282;
      $readmemh("sim/ctr_stream_vectors.hex", vec_mem);
      key_i = {vec_mem[0], vec_mem[1]};
      repeat (10) @(posedge m_axi_mm2s_aclk);
      rst_n_i <= 1'b1;
      @(posedge m_axi_mm2s_aclk);
      check_value("m_tvalid_o", m_tvalid_o, 1'b0);
      check_value("s_tready_o", s_tready_o, 1'b1);
      check_value("eof_empty_o", eof_empty_o, 1'b1);
      check_value("eof_full_o", eof_full_o, 1'b0);

      // All frames leave while the descriptor side stays idle
      drive_pass(0);
      drain(NBEATS);
      repeat (3) @(posedge m_axi_mm2s_aclk);
      check_value("eof_empty_o", eof_empty_o, 1'b0);
      check_value("eof_full_o", eof_full_o, 1'b1);
      check_value("s_tready_o", s_tready_o, 1'b0);

      repeat (EOF_DEPTH)
      begin
         @(posedge m_axi_mm2s_aclk);
         eof_rd_i <= 1'b1;
      end
      @(posedge m_axi_mm2s_aclk);
      eof_rd_i <= 1'b0;
      repeat (3) @(posedge m_axi_mm2s_aclk);
      check_value("eof_empty_o", eof_empty_o, 1'b1);
      check_value("eof_full_o", eof_full_o, 1'b0);
      check_value("s_tready_o", s_tready_o, 1'b1);

      // Frames are read back as they finish from here on
      eof_rd_i <= 1'b1;
      drive_pass(1);
      drain(2 * NBEATS);
      drive_pass(2);
      drain(3 * NBEATS);
      repeat (10) @(posedge m_axi_mm2s_aclk);
      check_value("m_tvalid_o", m_tvalid_o, 1'b0);
      check_value("beats_out", out_cnt, 3 * NBEATS);
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== sim/ctr_stream_vectors.hex ====
// Line 1 is the key, high half then low half
// Then one beat per line: last flag, input beat, expected output beat
5a5ac3c3000000000000000000000000 00000000000000000000000000000000
0 00112233445566778899aabbccddeeff 00112233445566778899aabbccddeeff
0 00000000000000000000000000000000 21e6da0cbd2246c8a5ae5e44b5e64e0c
1 00000000000000000000000000000000 42ccb5197b458c904a5dbd886acd9d18
0 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210
1 ffffffffffffffffffffffffffffffff de1925f342ddb9375a51a1bb4a19b1f3
0 ffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffff
0 21e6da0cbd2246c8a5ae5e44b5e64e0c 00000000000000000000000000000000
0 ffffffffffffffffffffffffffffffff bd334ae684ba736fb5a24277953262e7
1 00000000000000000000000000000000 632a6f15c667ca58eff3e3ccdf2bd314
0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
0 00000000000000000000000000000000 21e6da0cbd2246c8a5ae5e44b5e64e0c
1 ffffffffffffffffffffffffffffffff bd334ae684ba736fb5a24277953262e7
0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
0 00000000000000000000000000000000 21e6da0cbd2246c8a5ae5e44b5e64e0c
1 ffffffffffffffffffffffffffffffff bd334ae684ba736fb5a24277953262e7
1 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c
0 00000000000000000000000000000000 00000000000000000000000000000000
1 42ccb5197b458c904a5dbd886acd9d18 632a6f15c667ca58eff3e3ccdf2bd314
0 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f
0 ffffffffffffffffffffffffffffffff de1925f342ddb9375a51a1bb4a19b1f3
0 00000000000000000000000000000000 42ccb5197b458c904a5dbd886acd9d18
1 ffffffffffffffffffffffffffffffff 9cd590ea399835a7100c1c3320d42ceb
